// ==== Bender.yml ====
package:
  name: exec_stage

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - verilog/exec_pkg.sv
      - verilog/fpu_pkg.sv
      - verilog/exec_sequencer.sv
      - verilog/fp_add_sub.sv
      - verilog/fp_mul.sv
      - verilog/fpu_manager.sv
      - verilog/alu_unit.sv
      - verilog/exec_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - verif/exec_asserts.sv
      - verif/exec_tb.sv

// ==== build.f ====
+incdir+include
verilog/exec_pkg.sv
verilog/fpu_pkg.sv
verilog/exec_sequencer.sv
verilog/fp_add_sub.sv
verilog/fp_mul.sv
verilog/fpu_manager.sv
verilog/alu_unit.sv
verilog/exec_top.sv
verif/exec_asserts.sv
verif/exec_tb.sv

// ==== include/exec_config.svh ====
`ifndef EXEC_CONFIG_SVH
`define EXEC_CONFIG_SVH

// operand and command sizes
`define EXEC_DATA_W 32
`define EXEC_CODE_W 4

// single precision layout, sign + exp + frac fills EXEC_DATA_W
`define FP_EXP_W 8
`define FP_MAN_W 23
`define FP_BIAS  127

`endif

// ==== verif/exec_asserts.sv ====
`timescale 1ns/1ps

module exec_asserts (
  input logic                  clk,
  input logic                  rst,
  input logic                  clk_oe,
  input logic                  busy,
  input logic                  result_valid,
  input exec_pkg::alu_result_t result,
  input logic                  fpu_busy,
  input logic                  fpu_dn
);

  // stage idle right out of reset
  busy_after_reset: assert property (@(posedge clk) rst |=> !busy)
    else $error("busy high after reset");

  // result gated to zero outside alu_results
  zero_outside_window: assert property (@(posedge clk) disable iff (rst)
    !result_valid |-> result == '0)
    else $error("nonzero result without result_valid");

  // one enabled cycle, held edges keep it
  single_window: assert property (@(posedge clk) disable iff (rst)
    result_valid && clk_oe |=> !result_valid)
    else $error("result_valid longer than one enabled cycle");

  fpu_dn_in_busy: assert property (@(posedge clk) disable iff (rst) fpu_dn |-> fpu_busy)
    else $error("fpu done pulse outside fpu busy");

endmodule

bind exec_top exec_asserts u_asserts (
  .clk(clk), .rst(rst), .clk_oe(clk_oe), .busy(busy), .result_valid(result_valid),
  .result(result), .fpu_busy(fpu_busy), .fpu_dn(fpu_dn)
);

// ==== verif/exec_tb.sv ====
`timescale 1ns/1ps
`include "exec_config.svh"

module exec_tb;

  localparam int TIMEOUT = 200;  // cycles per wait

  logic                  clk;
  logic                  rst;
  logic                  clk_oe;
  logic                  cmd_valid;
  exec_pkg::command_t    command;
  logic                  busy;
  logic                  result_valid;
  exec_pkg::alu_result_t result;

  logic [31:0] lcg_state;
  logic        oe_random;   // clk_oe drawn at random per cycle
  logic        edge_en;     // clk_oe seen at the last rising edge
  logic        stalled;
  logic        rv_prev;
  int          int_errors, float_errors, zero_errors, protocol_errors, stalls;
  int          accepted, windows;

  exec_top dut (
    .clk(clk), .rst(rst), .clk_oe(clk_oe), .cmd_valid(cmd_valid), .command(command),
    .busy(busy), .result_valid(result_valid), .result(result)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;  // 40 ns period
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // mix of zero, small and full width values
  function automatic logic [31:0] rand_operand();
    logic [31:0] r;
    r = lcg_next();
    if (r[3:0] == 4'd0) return 32'd0;
    if (r[3:0] < 4'd5) return {24'd0, r[31:24]};
    return lcg_next();
  endfunction

  // exponent 110..144 with about one in eight zero
  function automatic logic [31:0] rand_float();
    logic [31:0] r;
    logic [31:0] f;
    logic [7:0]  e;
    r = lcg_next();
    f = lcg_next();
    e = 8'd110 + 8'(r[15:8] % 35);
    if (r[31:29] == 3'd0) return {r[0], 8'd0, f[22:0]};  // frac ignored with exp 0
    return {r[0], e, f[22:0]};
  endfunction

  function automatic exec_pkg::command_t make_cmd(input logic [3:0] code,
                                                  input logic [31:0] s0, input logic [31:0] s1);
    exec_pkg::command_t c;
    c.code = exec_pkg::cmd_code_t'(code);
    c.src0 = s0;
    c.src1 = s1;
    return c;
  endfunction

  function automatic logic is_float_code(input exec_pkg::command_t c);
    return c.code inside {exec_pkg::CMD_FADD, exec_pkg::CMD_FSUB, exec_pkg::CMD_FMUL};
  endfunction

  // exact alignment with dropped bits lost and a truncated result
  function automatic logic [31:0] fadd_model(input logic [31:0] a, input logic [31:0] b,
                                             input logic negate_b);
    fpu_pkg::fp_fields_t fa;
    fpu_pkg::fp_fields_t fb;
    logic [24:0] ma, mb, sum;  // hidden bit + carry room
    logic        sa, sb, sr;
    int          ea, eb, e;
    fa = a;
    fb = b;
    sa = fa.sign;
    sb = fb.sign ^ negate_b;
    ea = int'(fa.exp);
    eb = int'(fb.exp);
    ma = (fa.exp == 0) ? 25'd0 : {2'b01, fa.frac};
    mb = (fb.exp == 0) ? 25'd0 : {2'b01, fb.frac};
    if (ea >= eb) begin
      e  = ea;
      mb = mb >> (ea - eb);
    end else begin
      e  = eb;
      ma = ma >> (eb - ea);
    end
    if (sa == sb) begin
      sum = ma + mb;
      sr  = sa;
    end else if (ma >= mb) begin
      sum = ma - mb;
      sr  = sa;
    end else begin
      sum = mb - ma;
      sr  = sb;
    end
    if (sum == 0) return 32'd0;  // cancellation is +0
    if (sum[24]) begin
      sum = sum >> 1;
      e   = e + 1;
    end
    while (!sum[23]) begin
      sum = sum << 1;
      e   = e - 1;
    end
    if (e <= 0) return 32'd0;
    if (e >= 255) return {sr, 8'hff, 23'd0};
    return {sr, e[7:0], sum[22:0]};
  endfunction

  function automatic logic [31:0] fmul_model(input logic [31:0] a, input logic [31:0] b);
    fpu_pkg::fp_fields_t fa;
    fpu_pkg::fp_fields_t fb;
    logic [47:0] prod;
    int          e;
    fa = a;
    fb = b;
    if (fa.exp == 0 || fb.exp == 0) return 32'd0;
    prod = {1'b1, fa.frac} * {1'b1, fb.frac};
    e    = int'(fa.exp) + int'(fb.exp) - `FP_BIAS;
    if (prod[47]) begin  // product in [2,4)
      prod = prod >> 1;
      e    = e + 1;
    end
    if (e <= 0) return 32'd0;
    if (e >= 255) return {fa.sign ^ fb.sign, 8'hff, 23'd0};
    return {fa.sign ^ fb.sign, e[7:0], prod[45:23]};
  endfunction

  function automatic exec_pkg::alu_result_t expected_result(input exec_pkg::command_t c);
    exec_pkg::alu_result_t r;
    r = '0;
    case (c.code)
      exec_pkg::CMD_ADD: r = {32'd0, c.src0} + {32'd0, c.src1};
      exec_pkg::CMD_SUB: r = {32'd0, c.src0} - {32'd0, c.src1};  // borrow gives ones on top
      exec_pkg::CMD_MUL: r = {32'd0, c.src0} * {32'd0, c.src1};
      exec_pkg::CMD_DIV: begin
        r.dst   = (c.src1 == 0) ? 32'hffff_ffff : c.src0 / c.src1;
        r.dst_h = (c.src1 == 0) ? c.src0 : c.src0 % c.src1;
      end
      exec_pkg::CMD_SHR: if (c.src1 < 32) r.dst = c.src0 >> c.src1[4:0];
      exec_pkg::CMD_SHL: if (c.src1 < 32) r.dst = c.src0 << c.src1[4:0];
      exec_pkg::CMD_XOR: r.dst = c.src0 ^ c.src1;
      exec_pkg::CMD_AND: r.dst = c.src0 & c.src1;
      exec_pkg::CMD_OR:  r.dst = c.src0 | c.src1;
      exec_pkg::CMD_FADD: r.dst = fadd_model(c.src0, c.src1, 1'b0);
      exec_pkg::CMD_FSUB: r.dst = fadd_model(c.src0, c.src1, 1'b1);
      exec_pkg::CMD_FMUL: r.dst = fmul_model(c.src0, c.src1);
      default: r = '0;  // unknown code
    endcase
    return r;
  endfunction

  task automatic check_int_result(input exec_pkg::alu_result_t got,
                                  input exec_pkg::alu_result_t exp, input exec_pkg::command_t c);
    if (got !== exp) begin
      int_errors++;
      $display("[ERROR] %0t: int code %0d src %h %h gave %h_%h expected %h_%h", $time,
               c.code, c.src0, c.src1, got.dst_h, got.dst, exp.dst_h, exp.dst);
    end
  endtask

  task automatic check_float_result(input exec_pkg::alu_result_t got,
                                    input exec_pkg::alu_result_t exp, input exec_pkg::command_t c);
    if (got !== exp) begin
      float_errors++;
      $display("[ERROR] %0t: float code %0d src %h %h gave %h_%h expected %h_%h", $time,
               c.code, c.src0, c.src1, got.dst_h, got.dst, exp.dst_h, exp.dst);
    end
  endtask

  task automatic check_zero_result(input exec_pkg::alu_result_t got);
    if (got !== '0) begin
      zero_errors++;
      $display("[ERROR] %0t: result %h while result_valid is low", $time, got);
    end
  endtask

  task automatic report_stall(input string what);
    stalls++;
    stalled = 1'b1;  // remaining commands are skipped
    $display("timeout at %0t: %s", $time, what);
  endtask

  // one clock with inputs moving 2 ns after the edge
  task automatic tick();
    logic [31:0] r;
    @(posedge clk);
    edge_en = clk_oe;
    #2;
    r = lcg_next();
    clk_oe = oe_random ? (r[31:30] != 2'b00) : 1'b1;
  endtask

  task automatic run_command(input exec_pkg::command_t c, input logic stray);
    exec_pkg::alu_result_t exp_res;
    int                    n;
    int                    lat;
    if (stalled) return;
    exp_res = expected_result(c);
    n = 0;
    while (busy && n < TIMEOUT) begin
      tick();
      n++;
    end
    if (busy) begin
      report_stall("busy never dropped before a new command");
      return;
    end
    command   = c;
    cmd_valid = 1'b1;
    n = 0;
    do begin
      tick();
      n++;
    end while (!edge_en && n < TIMEOUT);
    cmd_valid = 1'b0;
    if (!edge_en) begin
      report_stall("clk_oe stayed low, command never taken");
      return;
    end
    accepted++;
    if (!busy) begin
      protocol_errors++;
      $display("[ERROR] %0t: busy low after the command was taken", $time);
    end
    lat = 0;
    n   = 0;
    while (!result_valid && n < TIMEOUT) begin
      if (stray && n == 0) begin  // second command while busy is dropped
        command.src0 = ~c.src0;
        command.src1 = c.src1 + 32'd7;
        cmd_valid    = 1'b1;
      end
      tick();
      cmd_valid = 1'b0;
      n++;
      if (edge_en) lat++;
    end
    if (!result_valid) begin
      report_stall("result_valid did not rise within 200 cycles of the command");
      return;
    end
    if (!oe_random && !is_float_code(c) && lat != 3) begin
      protocol_errors++;
      $display("[ERROR] %0t: result_valid %0d cycles after the command, expected 3",
               $time, lat);
    end
    if (is_float_code(c)) check_float_result(result, exp_res, c);
    else check_int_result(result, exp_res, c);
    n = 0;
    while (result_valid && n < TIMEOUT) begin
      tick();
      n++;
    end
    if (result_valid) begin
      report_stall("result_valid never dropped");
    end else if (busy) begin
      protocol_errors++;
      $display("[ERROR] %0t: busy still high after the result", $time);
    end
  endtask

  // zero result outside the window plus a window count
  always @(negedge clk) begin
    if (!rst) begin
      if (!result_valid) check_zero_result(result);
      if (result_valid && !rv_prev) windows++;
      rv_prev = result_valid;
    end
  end

  initial begin
    int          i;
    int          total;
    logic [31:0] x;
    lcg_state = 32'haf6dcbce;
    rst = 1'b1;
    clk_oe = 1'b1;
    cmd_valid = 1'b0;
    command = '0;
    oe_random = 1'b0;
    edge_en = 1'b0;
    stalled = 1'b0;
    rv_prev = 1'b0;
    int_errors = 0;
    float_errors = 0;
    zero_errors = 0;
    protocol_errors = 0;
    stalls = 0;
    accepted = 0;
    windows = 0;
    repeat (2) @(posedge clk);
    #2 rst = 1'b0;

    // add, sub, mul, div
    run_command(make_cmd(4'd1, 32'd3, 32'd10), 1'b0);  // borrow
    run_command(make_cmd(4'd3, 32'h1234_5678, 32'd0), 1'b0);  // divide by zero
    for (i = 0; i < 60; i++) begin
      x = lcg_next();
      run_command(make_cmd(4'(x[9:8]), rand_operand(), rand_operand()), 1'b0);
    end

    // shift amounts 0..40, boolean ops, unknown codes
    for (i = 0; i <= 40; i++) begin
      run_command(make_cmd(4'd4, lcg_next(), i), 1'b0);
      run_command(make_cmd(4'd5, lcg_next(), i), 1'b0);
    end
    for (i = 0; i < 30; i++) begin
      run_command(make_cmd(4'(6 + i % 3), lcg_next(), lcg_next()), 1'b0);
    end
    for (i = 12; i < 16; i++) run_command(make_cmd(4'(i), lcg_next(), lcg_next()), 1'b0);

    // float ops then cancellation to +0
    for (i = 0; i < 90; i++) begin
      run_command(make_cmd(4'(9 + i % 3), rand_float(), rand_float()), 1'b0);
    end
    for (i = 0; i < 6; i++) begin
      x = lcg_next();
      x = {i[0], 8'd120 + 8'(i), x[22:0]};  // sign alternates
      run_command(make_cmd(4'd10, x, x), 1'b0);
      run_command(make_cmd(4'd9, x, x ^ 32'h8000_0000), 1'b0);
    end

    // clk_oe toggling with any code
    oe_random = 1'b1;
    for (i = 0; i < 80; i++) begin
      x = lcg_next();
      if (x[3:0] >= 4'd9 && x[3:0] <= 4'd11) run_command(make_cmd(x[3:0], rand_float(),
                                                                  rand_float()), 1'b0);
      else run_command(make_cmd(x[3:0], rand_operand(), rand_operand()), 1'b0);
    end
    oe_random = 1'b0;
    if (!stalled) tick();  // back to a steady clk_oe

    // second pulse while busy is ignored
    for (i = 0; i < 12; i++) begin
      x = lcg_next();
      run_command(make_cmd(4'(x[1:0] + (i[0] ? 4'd0 : 4'd9)), rand_float(), rand_float()), 1'b1);
    end

    repeat (2) @(negedge clk);  // let the monitor see the last window
    if (windows != accepted) begin
      protocol_errors++;
      $display("[ERROR] %0t: %0d result windows for %0d accepted commands", $time,
               windows, accepted);
    end
    total = int_errors + float_errors + zero_errors + protocol_errors + stalls;
    $display("errors: int %0d, float %0d, zero %0d, protocol %0d, timeouts %0d",
             int_errors, float_errors, zero_errors, protocol_errors, stalls);
    if (total == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

// ==== verilog/alu_unit.sv ====
`timescale 1ns/1ps
`include "exec_config.svh"

module alu_unit (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    clk_oe,
  input  exec_pkg::exec_state_t   state,
  input  exec_pkg::command_t      cmd,
  input  logic                    fpu_busy,
  input  logic                    fpu_dn,
  input  logic [`EXEC_DATA_W-1:0] fpu_out,
  output fpu_pkg::fp_op_t         fpu_op,
  output logic [`EXEC_DATA_W-1:0] fpu_a,
  output logic [`EXEC_DATA_W-1:0] fpu_b,
  output logic                    fpu_q,
  output logic                    next_state,
  output exec_pkg::alu_result_t   result
);

  localparam int DW = `EXEC_DATA_W;

  exec_pkg::alu_result_t res_r;
  logic [2*DW-1:0]       wide_a;     // zero-extended operands
  logic [2*DW-1:0]       wide_b;
  logic                  finished;   // op done, waiting for the state to move
  logic                  requested;  // fpu request already sent
  logic                  is_float;
  logic                  compute;
  logic                  issue;
  logic                  fpu_take;
  logic                  complete;
  fpu_pkg::fp_op_t       op_sel;

  assign wide_a = {{DW{1'b0}}, cmd.src0};
  assign wide_b = {{DW{1'b0}}, cmd.src1};

  // fpu latches these on q
  assign fpu_a = cmd.src0;
  assign fpu_b = cmd.src1;

  always_comb begin
    is_float = 1'b1;
    op_sel   = fpu_pkg::FP_ADD;
    case (cmd.code)
      exec_pkg::CMD_FADD: op_sel = fpu_pkg::FP_ADD;
      exec_pkg::CMD_FSUB: op_sel = fpu_pkg::FP_SUB;
      exec_pkg::CMD_FMUL: op_sel = fpu_pkg::FP_MUL;
      default:            is_float = 1'b0;
    endcase
  end

  assign compute  = (state == exec_pkg::ALU_BEGIN) && !finished;
  assign issue    = compute && is_float && !requested && !fpu_busy;
  assign fpu_take = requested && fpu_dn;
  assign complete = compute && (!is_float || fpu_take);  // integer ops take one cycle

  // control
  always_ff @(posedge clk) begin
    if (rst) begin
      next_state <= 1'b0;
      finished   <= 1'b0;
      requested  <= 1'b0;
      fpu_q      <= 1'b0;
    end else if (!clk_oe) begin
      next_state <= 1'b0;  // a held edge drops the pulse
    end else begin
      fpu_q <= issue;  // single cycle request
      if (state != exec_pkg::ALU_BEGIN) begin
        finished   <= 1'b0;
        requested  <= 1'b0;
        next_state <= 1'b0;
      end else if (finished) begin
        next_state <= !next_state;  // re-raise if a held edge ate it
      end else begin
        if (issue) requested <= 1'b1;
        if (complete) begin
          finished   <= 1'b1;
          next_state <= 1'b1;
        end
      end
    end
  end

  // datapath
  always_ff @(posedge clk) begin
    if (clk_oe && compute) begin
      if (is_float) begin
        if (issue) fpu_op <= op_sel;
        if (fpu_take) begin
          res_r.dst   <= fpu_out;
          res_r.dst_h <= '0;
        end
      end else begin
        case (cmd.code)
          exec_pkg::CMD_ADD: res_r <= wide_a + wide_b;
          exec_pkg::CMD_SUB: res_r <= wide_a - wide_b;  // borrow fills dst_h
          exec_pkg::CMD_MUL: res_r <= wide_a * wide_b;
          exec_pkg::CMD_DIV: begin
            if (cmd.src1 == '0) begin
              res_r.dst   <= '1;
              res_r.dst_h <= cmd.src0;
            end else begin
              res_r.dst   <= cmd.src0 / cmd.src1;
              res_r.dst_h <= cmd.src0 % cmd.src1;
            end
          end
          // full 32-bit amount, 32 and up shifts everything out
          exec_pkg::CMD_SHR: res_r <= {{DW{1'b0}}, cmd.src0 >> cmd.src1};
          exec_pkg::CMD_SHL: res_r <= {{DW{1'b0}}, cmd.src0 << cmd.src1};
          exec_pkg::CMD_XOR: res_r <= {{DW{1'b0}}, cmd.src0 ^ cmd.src1};
          exec_pkg::CMD_AND: res_r <= {{DW{1'b0}}, cmd.src0 & cmd.src1};
          exec_pkg::CMD_OR:  res_r <= {{DW{1'b0}}, cmd.src0 | cmd.src1};
          default:           res_r <= '0;  // unknown code completes empty
        endcase
      end
    end
  end

  // result only visible in alu_results
  assign result = (state == exec_pkg::ALU_RESULTS) ? res_r : '0;

endmodule

// ==== verilog/exec_pkg.sv ====
`include "exec_config.svh"

package exec_pkg;

  // command codes, anything above CMD_FMUL is unknown
  typedef enum logic [`EXEC_CODE_W-1:0] {
    CMD_ADD  = 0,
    CMD_SUB  = 1,
    CMD_MUL  = 2,
    CMD_DIV  = 3,   // quotient + remainder
    CMD_SHR  = 4,
    CMD_SHL  = 5,
    CMD_XOR  = 6,
    CMD_AND  = 7,
    CMD_OR   = 8,
    CMD_FADD = 9,   // handed to the fpu
    CMD_FSUB = 10,
    CMD_FMUL = 11
  } cmd_code_t;

  typedef enum logic [1:0] {
    IDLE        = 2'd0,
    ALU_BEGIN   = 2'd1,  // op in progress
    ALU_RESULTS = 2'd2   // result on the outputs for one enabled cycle
  } exec_state_t;

  typedef struct packed {
    cmd_code_t               code;
    logic [`EXEC_DATA_W-1:0] src0;
    logic [`EXEC_DATA_W-1:0] src1;
  } command_t;

  typedef struct packed {
    logic [`EXEC_DATA_W-1:0] dst_h;  // upper word / remainder
    logic [`EXEC_DATA_W-1:0] dst;
  } alu_result_t;

endpackage

// ==== verilog/exec_sequencer.sv ====
`timescale 1ns/1ps

module exec_sequencer (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  clk_oe,
  input  logic                  cmd_valid,
  input  exec_pkg::command_t    command,
  input  logic                  next_state,
  output logic                  busy,
  output exec_pkg::exec_state_t state,
  output exec_pkg::command_t    cmd
);

  logic pending;  // command latched, begin starts next enabled edge
  logic accept;

  // pulses while busy are dropped
  assign accept = cmd_valid && !busy;
  assign busy   = pending || (state != exec_pkg::IDLE);

  always_ff @(posedge clk) begin
    if (rst) begin
      state   <= exec_pkg::IDLE;
      pending <= 1'b0;
    end else if (clk_oe) begin
      case (state)
        exec_pkg::IDLE: begin
          if (pending) begin
            state   <= exec_pkg::ALU_BEGIN;
            pending <= 1'b0;
          end else if (accept) begin
            pending <= 1'b1;
          end
        end
        exec_pkg::ALU_BEGIN: begin
          if (next_state) state <= exec_pkg::ALU_RESULTS;  // alu finished
        end
        exec_pkg::ALU_RESULTS: begin
          state <= exec_pkg::IDLE;  // result shown for one enabled cycle
        end
        default: begin
          state <= exec_pkg::IDLE;
        end
      endcase
    end
  end

  // command word held for the whole op
  always_ff @(posedge clk) begin
    if (clk_oe && accept) begin
      cmd <= command;
    end
  end

endmodule

// ==== verilog/exec_top.sv ====
`timescale 1ns/1ps
`include "exec_config.svh"

module exec_top (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  clk_oe,
  input  logic                  cmd_valid,
  input  exec_pkg::command_t    command,
  output logic                  busy,
  output logic                  result_valid,
  output exec_pkg::alu_result_t result
);

  exec_pkg::exec_state_t   state;
  exec_pkg::command_t      cmd;
  logic                    next_state;
  fpu_pkg::fp_op_t         fpu_op;
  logic [`EXEC_DATA_W-1:0] fpu_a;
  logic [`EXEC_DATA_W-1:0] fpu_b;
  logic [`EXEC_DATA_W-1:0] fpu_out;
  logic                    fpu_q;
  logic                    fpu_busy;
  logic                    fpu_dn;

  assign result_valid = (state == exec_pkg::ALU_RESULTS);

  exec_sequencer u_seq (
    .clk(clk), .rst(rst), .clk_oe(clk_oe),
    .cmd_valid(cmd_valid), .command(command), .next_state(next_state),
    .busy(busy), .state(state), .cmd(cmd)
  );

  alu_unit u_alu (
    .clk(clk), .rst(rst), .clk_oe(clk_oe),
    .state(state), .cmd(cmd),
    .fpu_busy(fpu_busy), .fpu_dn(fpu_dn), .fpu_out(fpu_out),
    .fpu_op(fpu_op), .fpu_a(fpu_a), .fpu_b(fpu_b), .fpu_q(fpu_q),
    .next_state(next_state), .result(result)
  );

  fpu_manager u_fpu (
    .clk(clk), .rst(rst), .clk_oe(clk_oe),
    .op(fpu_op), .a(fpu_a), .b(fpu_b), .q(fpu_q),
    .busy(fpu_busy), .dn(fpu_dn), .out(fpu_out)
  );

endmodule

// ==== verilog/fp_add_sub.sv ====
`timescale 1ns/1ps
`include "exec_config.svh"

module fp_add_sub (
  input  logic                clk,
  input  logic                rst,
  input  logic                clk_oe,
  input  logic                start,
  input  logic                sub,
  input  fpu_pkg::fp_fields_t a,
  input  fpu_pkg::fp_fields_t b,
  output logic                done,
  output fpu_pkg::fp_fields_t y
);

  localparam int MAN_W   = `FP_MAN_W;
  localparam int EXP_W   = `FP_EXP_W;
  localparam int MW      = MAN_W + 1;  // with hidden bit
  localparam int EW      = EXP_W + 2;  // sign and carry room
  localparam int LZ_W    = $clog2(MW + 1);
  localparam int EXP_MAX = (1 << EXP_W) - 1;

  logic                 run;
  logic                 aligned;
  logic                 a_zero;
  logic                 b_zero;
  logic [EXP_W-1:0]     ea;
  logic [EXP_W-1:0]     eb;
  logic [MW-1:0]        ma;
  logic [MW-1:0]        mb;
  logic                 sa;
  logic                 sb;
  logic [MW:0]          mag;     // magnitude incl carry out
  logic                 rsign;
  logic [LZ_W-1:0]      lz;
  logic [MW-1:0]        norm;
  logic [MAN_W-1:0]     frac;
  logic signed [EW-1:0] e_res;
  fpu_pkg::fp_fields_t  y_next;

  function automatic logic [LZ_W-1:0] lead_zeros(input logic [MW-1:0] v);
    logic [LZ_W-1:0] n;
    logic            hit;
    n   = '0;
    hit = 1'b0;
    for (int i = MW - 1; i >= 0; i--) begin
      if (v[i]) hit = 1'b1;
      else if (!hit) n = n + 1'b1;
    end
    return n;
  endfunction

  assign a_zero  = (a.exp == '0);
  assign b_zero  = (b.exp == '0);
  assign aligned = (ea == eb);

  always_ff @(posedge clk) begin
    if (rst) begin
      run  <= 1'b0;
      done <= 1'b0;
    end else if (clk_oe) begin
      done <= run && aligned;  // last cycle packs the result
      if (start) run <= 1'b1;
      else if (aligned) run <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (clk_oe) begin
      if (start) begin
        // zero operand borrows the other exponent, nothing to align
        ma <= a_zero ? '0 : {1'b1, a.frac};
        mb <= b_zero ? '0 : {1'b1, b.frac};
        ea <= a_zero ? b.exp : a.exp;
        eb <= b_zero ? a.exp : b.exp;
        sa <= a.sign;
        sb <= b.sign ^ sub;  // subtract as add of negated b
      end else if (run) begin
        if (ea > eb) begin
          mb <= mb >> 1;  // dropped bits lost, truncation
          eb <= eb + 1'b1;
        end else if (eb > ea) begin
          ma <= ma >> 1;
          ea <= ea + 1'b1;
        end else begin
          y <= y_next;
        end
      end
    end
  end

  always_comb begin
    rsign = sa;
    if (sa == sb) begin
      mag = ma + mb;
    end else if (ma >= mb) begin
      mag = ma - mb;
    end else begin
      mag   = mb - ma;
      rsign = sb;
    end
    lz   = lead_zeros(mag[MW-1:0]);
    norm = mag[MW-1:0] << lz;
    if (mag[MW]) begin
      frac  = mag[MW-1 -: MAN_W];  // carry out, shift right by one
      e_res = EW'(ea) + EW'(1);
    end else begin
      frac  = norm[MAN_W-1:0];
      e_res = EW'(ea) - EW'(lz);
    end
    y_next = '0;  // cancellation and underflow give +0
    if (mag != '0 && e_res > 0) begin
      y_next.sign = rsign;
      if (e_res >= EXP_MAX) begin
        y_next.exp = '1;  // infinity
      end else begin
        y_next.exp  = e_res[EXP_W-1:0];
        y_next.frac = frac;
      end
    end
  end

endmodule

// ==== verilog/fp_mul.sv ====
`timescale 1ns/1ps
`include "exec_config.svh"

module fp_mul (
  input  logic                clk,
  input  logic                rst,
  input  logic                clk_oe,
  input  logic                start,
  input  fpu_pkg::fp_fields_t a,
  input  fpu_pkg::fp_fields_t b,
  output logic                done,
  output fpu_pkg::fp_fields_t y
);

  localparam int MAN_W   = `FP_MAN_W;
  localparam int EXP_W   = `FP_EXP_W;
  localparam int PW      = 2 * (MAN_W + 1);  // full mantissa product
  localparam int EW      = EXP_W + 2;
  localparam int EXP_MAX = (1 << EXP_W) - 1;

  logic                 v1;       // stage one holds a request
  logic                 s1_sign;
  logic                 s1_zero;
  logic signed [EW-1:0] s1_exp;   // unbiased sum, may go negative
  logic [PW-1:0]        s1_prod;
  logic signed [EW-1:0] e_norm;
  logic [MAN_W-1:0]     frac;
  fpu_pkg::fp_fields_t  y_next;

  always_ff @(posedge clk) begin
    if (rst) begin
      v1   <= 1'b0;
      done <= 1'b0;
    end else if (clk_oe) begin
      v1   <= start;
      done <= v1;
    end
  end

  always_ff @(posedge clk) begin
    if (clk_oe && start) begin
      s1_sign <= a.sign ^ b.sign;
      s1_zero <= (a.exp == '0) || (b.exp == '0);
      s1_exp  <= EW'(a.exp) + EW'(b.exp) - EW'(`FP_BIAS);
      s1_prod <= {1'b1, a.frac} * {1'b1, b.frac};
    end
    if (clk_oe && v1) begin
      y <= y_next;
    end
  end

  // product lies in [1,4), at most one position to normalize
  always_comb begin
    e_norm = s1_exp + EW'(s1_prod[PW-1]);
    frac   = s1_prod[PW-1] ? s1_prod[PW-2 -: MAN_W] : s1_prod[PW-3 -: MAN_W];
    y_next = '0;
    if (!s1_zero && e_norm > 0) begin
      y_next.sign = s1_sign;
      if (e_norm >= EXP_MAX) begin
        y_next.exp = '1;  // overflow to infinity
      end else begin
        y_next.exp  = e_norm[EXP_W-1:0];
        y_next.frac = frac;
      end
    end
  end

endmodule

// ==== verilog/fpu_manager.sv ====
`timescale 1ns/1ps
`include "exec_config.svh"

module fpu_manager (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    clk_oe,
  input  fpu_pkg::fp_op_t         op,
  input  logic [`EXEC_DATA_W-1:0] a,
  input  logic [`EXEC_DATA_W-1:0] b,
  input  logic                    q,
  output logic                    busy,
  output logic                    dn,
  output logic [`EXEC_DATA_W-1:0] out
);

  fpu_pkg::fp_op_t     op_r;
  fpu_pkg::fp_fields_t a_r;
  fpu_pkg::fp_fields_t b_r;
  fpu_pkg::fp_fields_t add_y;
  fpu_pkg::fp_fields_t mul_y;
  fpu_pkg::fp_fields_t unit_y;
  logic                start_add;
  logic                start_mul;
  logic                add_done;
  logic                mul_done;
  logic                unit_done;
  logic                accept;
  logic                is_sub;

  assign accept    = q && !busy;
  assign is_sub    = (op_r == fpu_pkg::FP_SUB);
  assign unit_done = (op_r == fpu_pkg::FP_MUL) ? mul_done : add_done;  // only the started unit
  assign unit_y    = (op_r == fpu_pkg::FP_MUL) ? mul_y : add_y;

  always_ff @(posedge clk) begin
    if (rst) begin
      busy      <= 1'b0;
      dn        <= 1'b0;
      start_add <= 1'b0;
      start_mul <= 1'b0;
    end else if (clk_oe) begin
      start_add <= accept && (op != fpu_pkg::FP_MUL);
      start_mul <= accept && (op == fpu_pkg::FP_MUL);
      dn        <= busy && !dn && unit_done;
      if (accept) busy <= 1'b1;
      else if (dn) busy <= 1'b0;  // busy overlaps dn by one cycle
    end
  end

  always_ff @(posedge clk) begin
    if (clk_oe && accept) begin
      a_r  <= a;
      b_r  <= b;
      op_r <= op;
    end
    if (clk_oe && busy && !dn && unit_done) begin
      out <= unit_y;
    end
  end

  fp_add_sub u_add_sub (
    .clk    (clk),
    .rst    (rst),
    .clk_oe (clk_oe),
    .start  (start_add),
    .sub    (is_sub),
    .a      (a_r),
    .b      (b_r),
    .done   (add_done),
    .y      (add_y)
  );

  fp_mul u_mul (
    .clk    (clk),
    .rst    (rst),
    .clk_oe (clk_oe),
    .start  (start_mul),
    .a      (a_r),
    .b      (b_r),
    .done   (mul_done),
    .y      (mul_y)
  );

endmodule

// ==== verilog/fpu_pkg.sv ====
`include "exec_config.svh"

package fpu_pkg;

  // float ops the manager can run
  typedef enum logic [1:0] {
    FP_ADD = 2'd0,
    FP_SUB = 2'd1,
    FP_MUL = 2'd2
  } fp_op_t;

  // single precision word split into its fields
  typedef struct packed {
    logic                 sign;
    logic [`FP_EXP_W-1:0] exp;   // biased, zero means a zero operand here
    logic [`FP_MAN_W-1:0] frac;  // hidden bit not stored
  } fp_fields_t;

endpackage
